//--- logic/cache_pkg.sv
package cache_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths

    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 32;
    localparam int BYTES_W   = DATA_W / 8;
    localparam int TAG_W     = 6;
    // Core tag plus the NC flag on top
    localparam int MEM_TAG_W = TAG_W + 1;

    typedef logic [ADDR_W-1:0]    word_addr_t;
    typedef logic [DATA_W-1:0]    word_data_t;
    typedef logic [BYTES_W-1:0]   byteen_t;
    typedef logic [TAG_W-1:0]     core_tag_t;
    typedef logic [MEM_TAG_W-1:0] mem_tag_t;

    //////////////////////////////////////////////////////////////////////
    // Channel payloads

    typedef struct packed {
        logic       rw;
        word_addr_t addr;
        byteen_t    byteen;
        word_data_t data;
        core_tag_t  tag;
    } core_req_t;

    typedef struct packed {
        word_data_t data;
        core_tag_t  tag;
    } core_rsp_t;

    typedef struct packed {
        logic       rw;
        word_addr_t addr;
        byteen_t    byteen;
        word_data_t data;
        mem_tag_t   tag;
    } mem_req_t;

    typedef struct packed {
        word_data_t data;
        mem_tag_t   tag;
    } mem_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // Cache core FSM

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FILL_REQ,
        FILL_WAIT,
        RESPOND
    } cache_state_t;

endpackage

//--- logic/skid_buffer.sv
module skid_buffer #(
    parameter int DATAW = 32
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             valid_in,
    input  logic [DATAW-1:0] data_in,
    output logic             ready_in,

    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  logic             ready_out
);

    logic             main_valid;
    logic             skid_valid;
    logic [DATAW-1:0] main_data;
    logic [DATAW-1:0] skid_data;
    logic             load_main;

    // Main register empty or draining this cycle
    assign load_main = ready_out || !main_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_main) begin
            if (skid_valid) begin
                main_valid <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                main_valid <= valid_in;
            end
        end else if (valid_in && !skid_valid) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_main) begin
            main_data <= skid_valid ? skid_data : data_in;
        end
        if (!load_main && !skid_valid) begin
            skid_data <= data_in;
        end
    end

    // Registered ready, one spare slot behind the main register
    assign ready_in  = !skid_valid;
    assign valid_out = main_valid;
    assign data_out  = main_data;

    a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
        valid_out && !ready_out |=> valid_out && $stable(data_out));

endmodule

//--- logic/nc_bypass.sv
module nc_bypass
    import cache_pkg::*;
#(
    parameter int NC_ADDR_BIT = 15
) (
    input  logic      clk,
    input  logic      reset,

    // Core side
    input  core_req_t core_req,
    input  logic      core_req_valid,
    output logic      core_req_ready,
    input  mem_rsp_t  mem_rsp,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready,

    // Cache core side
    output core_req_t cache_req,
    output logic      cache_req_valid,
    input  logic      cache_req_ready,
    input  core_rsp_t cache_rsp,
    input  logic      cache_rsp_valid,
    output logic      cache_rsp_ready,
    input  mem_req_t  cache_mem_req,
    input  logic      cache_mem_req_valid,
    output logic      cache_mem_req_ready,
    output mem_rsp_t  cache_mem_rsp,
    output logic      cache_mem_rsp_valid,
    input  logic      cache_mem_rsp_ready,

    // Buffer side
    output mem_req_t  mem_req_out,
    output logic      mem_req_out_valid,
    input  logic      mem_req_out_ready,
    output core_rsp_t core_rsp_out,
    output logic      core_rsp_out_valid,
    input  logic      core_rsp_out_ready
);

    localparam int NUM_TAGS = 1 << TAG_W;

    logic      req_is_nc;
    logic      rsp_is_nc;
    mem_req_t  byp_mem_req;
    mem_req_t  cache_mem_req_tagged;
    core_rsp_t byp_core_rsp;
    logic      byp_req_valid;
    logic      byp_rsp_valid;

    //////////////////////////////////////////////////////////////////////
    // Request steering

    assign req_is_nc = core_req.addr[NC_ADDR_BIT];

    assign cache_req       = core_req;
    assign cache_req_valid = core_req_valid && !req_is_nc;
    assign byp_req_valid   = core_req_valid && req_is_nc;

    // NC flag set on bypassed requests, cleared on cache requests
    assign byp_mem_req = '{
        rw:     core_req.rw,
        addr:   core_req.addr,
        byteen: core_req.byteen,
        data:   core_req.data,
        tag:    {1'b1, core_req.tag}
    };

    always_comb begin
        cache_mem_req_tagged = cache_mem_req;
        cache_mem_req_tagged.tag[MEM_TAG_W-1] = 1'b0;
    end

    // Cache core wins the memory request port
    assign mem_req_out_valid   = cache_mem_req_valid || byp_req_valid;
    assign mem_req_out         = cache_mem_req_valid ? cache_mem_req_tagged : byp_mem_req;
    assign cache_mem_req_ready = mem_req_out_ready;

    assign core_req_ready = req_is_nc ? (mem_req_out_ready && !cache_mem_req_valid)
                                      : cache_req_ready;

    //////////////////////////////////////////////////////////////////////
    // Response steering

    assign rsp_is_nc = mem_rsp.tag[MEM_TAG_W-1];

    assign cache_mem_rsp = '{
        data: mem_rsp.data,
        tag:  {1'b0, mem_rsp.tag[TAG_W-1:0]}
    };
    assign cache_mem_rsp_valid = mem_rsp_valid && !rsp_is_nc;

    assign byp_core_rsp = '{
        data: mem_rsp.data,
        tag:  mem_rsp.tag[TAG_W-1:0]
    };
    assign byp_rsp_valid = mem_rsp_valid && rsp_is_nc;

    // Cache core wins the core response port
    assign core_rsp_out_valid = cache_rsp_valid || byp_rsp_valid;
    assign core_rsp_out       = cache_rsp_valid ? cache_rsp : byp_core_rsp;
    assign cache_rsp_ready    = core_rsp_out_ready;

    assign mem_rsp_ready = rsp_is_nc ? (core_rsp_out_ready && !cache_rsp_valid)
                                     : cache_mem_rsp_ready;

    //////////////////////////////////////////////////////////////////////
    // Outstanding bypassed reads, per core tag

    logic [NUM_TAGS-1:0] nc_pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            nc_pending <= '0;
        end else begin
            if (byp_rsp_valid && mem_rsp_ready) begin
                nc_pending[mem_rsp.tag[TAG_W-1:0]] <= 1'b0;
            end
            if (byp_req_valid && core_req_ready && !core_req.rw) begin
                nc_pending[core_req.tag] <= 1'b1;
            end
        end
    end

    a_nc_rsp_known: assert property (@(posedge clk) disable iff (reset)
        byp_rsp_valid |-> nc_pending[mem_rsp.tag[TAG_W-1:0]]);

endmodule

//--- logic/cache_core.sv
module cache_core
    import cache_pkg::*;
#(
    parameter int NUM_LINES = 16
) (
    input  logic      clk,
    input  logic      reset,

    input  core_req_t req,
    input  logic      req_valid,
    output logic      req_ready,

    output core_rsp_t rsp,
    output logic      rsp_valid,
    input  logic      rsp_ready,

    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,

    input  mem_rsp_t  mem_rsp,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready
);

    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam int LTAG_W  = ADDR_W - INDEX_W;

    cache_state_t state;
    cache_state_t next_state;

    // Line storage, indexed by the low address bits
    logic [NUM_LINES-1:0] line_valid;
    logic [LTAG_W-1:0]    line_tag [NUM_LINES];
    word_data_t           line_data [NUM_LINES];

    core_req_t            req_q;
    word_data_t           rsp_data;

    logic [INDEX_W-1:0]   idx;
    logic [LTAG_W-1:0]    atag;
    logic                 hit;
    word_data_t           merged;

    assign idx  = req_q.addr[INDEX_W-1:0];
    assign atag = req_q.addr[ADDR_W-1:INDEX_W];
    assign hit  = line_valid[idx] && (line_tag[idx] == atag);

    // Byte merge of a write into the current line contents
    always_comb begin
        merged = line_data[idx];
        for (int i = 0; i < BYTES_W; i++) begin
            if (req_q.byteen[i]) begin
                merged[i*8 +: 8] = req_q.data[i*8 +: 8];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Miss FSM

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (req_valid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (req_q.rw || !hit) begin
                    next_state = FILL_REQ;
                end else begin
                    next_state = RESPOND;
                end
            end
            FILL_REQ: begin
                // Writes finish once memory takes them
                if (mem_req_ready) begin
                    next_state = req_q.rw ? IDLE : FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (mem_rsp_valid) begin
                    next_state = RESPOND;
                end
            end
            RESPOND: begin
                if (rsp_ready) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            line_valid <= '0;
        end else begin
            state <= next_state;
            if (state == FILL_WAIT && mem_rsp_valid) begin
                line_valid[idx] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request, response and line payloads

    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            req_q <= req;
        end
        if (state == LOOKUP) begin
            rsp_data <= line_data[idx];
            // Write hit updates the line; a write miss leaves it alone
            if (req_q.rw && hit) begin
                line_data[idx] <= merged;
            end
        end
        if (state == FILL_WAIT && mem_rsp_valid) begin
            line_tag[idx]  <= atag;
            line_data[idx] <= mem_rsp.data;
            rsp_data       <= mem_rsp.data;
        end
    end

    assign req_ready = (state == IDLE);

    assign rsp_valid = (state == RESPOND);
    assign rsp       = '{data: rsp_data, tag: req_q.tag};

    assign mem_req_valid = (state == FILL_REQ);
    assign mem_req = '{
        rw:     req_q.rw,
        addr:   req_q.addr,
        byteen: req_q.byteen,
        data:   req_q.data,
        tag:    {1'b0, req_q.tag}
    };

    assign mem_rsp_ready = (state == FILL_WAIT);

    // Fill data only shows up for the read in flight
    a_fill_only_waiting: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_rsp_valid) |-> (state == FILL_WAIT) && (mem_rsp.tag == {1'b0, req_q.tag}));

endmodule

//--- logic/cache_wrap.sv
module cache_wrap
    import cache_pkg::*;
#(
    parameter int NUM_LINES   = 16,
    parameter int NC_ADDR_BIT = 15
) (
    input  logic      clk,
    input  logic      reset,

    input  core_req_t core_req,
    input  logic      core_req_valid,
    output logic      core_req_ready,

    output core_rsp_t core_rsp,
    output logic      core_rsp_valid,
    input  logic      core_rsp_ready,

    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,

    input  mem_rsp_t  mem_rsp,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready
);

    core_req_t cache_req;
    logic      cache_req_valid;
    logic      cache_req_ready;
    core_rsp_t cache_rsp;
    logic      cache_rsp_valid;
    logic      cache_rsp_ready;
    mem_req_t  cache_mem_req;
    logic      cache_mem_req_valid;
    logic      cache_mem_req_ready;
    mem_rsp_t  cache_mem_rsp;
    logic      cache_mem_rsp_valid;
    logic      cache_mem_rsp_ready;

    // Merged outputs ahead of the skid buffers
    mem_req_t  mem_req_s;
    logic      mem_req_s_valid;
    logic      mem_req_s_ready;
    core_rsp_t core_rsp_s;
    logic      core_rsp_s_valid;
    logic      core_rsp_s_ready;

    nc_bypass #(
        .NC_ADDR_BIT (NC_ADDR_BIT)
    ) u_nc_bypass (
        .clk                 (clk),
        .reset               (reset),
        .core_req            (core_req),
        .core_req_valid      (core_req_valid),
        .core_req_ready      (core_req_ready),
        .mem_rsp             (mem_rsp),
        .mem_rsp_valid       (mem_rsp_valid),
        .mem_rsp_ready       (mem_rsp_ready),
        .cache_req           (cache_req),
        .cache_req_valid     (cache_req_valid),
        .cache_req_ready     (cache_req_ready),
        .cache_rsp           (cache_rsp),
        .cache_rsp_valid     (cache_rsp_valid),
        .cache_rsp_ready     (cache_rsp_ready),
        .cache_mem_req       (cache_mem_req),
        .cache_mem_req_valid (cache_mem_req_valid),
        .cache_mem_req_ready (cache_mem_req_ready),
        .cache_mem_rsp       (cache_mem_rsp),
        .cache_mem_rsp_valid (cache_mem_rsp_valid),
        .cache_mem_rsp_ready (cache_mem_rsp_ready),
        .mem_req_out         (mem_req_s),
        .mem_req_out_valid   (mem_req_s_valid),
        .mem_req_out_ready   (mem_req_s_ready),
        .core_rsp_out        (core_rsp_s),
        .core_rsp_out_valid  (core_rsp_s_valid),
        .core_rsp_out_ready  (core_rsp_s_ready)
    );

    cache_core #(
        .NUM_LINES (NUM_LINES)
    ) u_cache_core (
        .clk           (clk),
        .reset         (reset),
        .req           (cache_req),
        .req_valid     (cache_req_valid),
        .req_ready     (cache_req_ready),
        .rsp           (cache_rsp),
        .rsp_valid     (cache_rsp_valid),
        .rsp_ready     (cache_rsp_ready),
        .mem_req       (cache_mem_req),
        .mem_req_valid (cache_mem_req_valid),
        .mem_req_ready (cache_mem_req_ready),
        .mem_rsp       (cache_mem_rsp),
        .mem_rsp_valid (cache_mem_rsp_valid),
        .mem_rsp_ready (cache_mem_rsp_ready)
    );

    skid_buffer #(
        .DATAW ($bits(mem_req_t))
    ) u_mem_req_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (mem_req_s_valid),
        .data_in   (mem_req_s),
        .ready_in  (mem_req_s_ready),
        .valid_out (mem_req_valid),
        .data_out  (mem_req),
        .ready_out (mem_req_ready)
    );

    skid_buffer #(
        .DATAW ($bits(core_rsp_t))
    ) u_core_rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (core_rsp_s_valid),
        .data_in   (core_rsp_s),
        .ready_in  (core_rsp_s_ready),
        .valid_out (core_rsp_valid),
        .data_out  (core_rsp),
        .ready_out (core_rsp_ready)
    );

endmodule

//--- testbench/mem_model.sv
module mem_model
    import cache_pkg::*;
#(
    parameter int MAX_DELAY = 6
) (
    input  logic     clk,
    input  logic     reset,

    input  mem_req_t mem_req,
    input  logic     mem_req_valid,
    output logic     mem_req_ready,

    output mem_rsp_t mem_rsp,
    output logic     mem_rsp_valid,
    input  logic     mem_rsp_ready
);

    word_data_t mem [word_addr_t];
    mem_rsp_t   rsp_q [$];
    int         due_q [$];
    int         cycle = 0;
    int         delay_pick = 0;
    integer     seed = 32'h6ed1;

    // Contents of a word never written
    function automatic word_data_t blank_word(word_addr_t a);
        return {a ^ 16'hc35a, ~a};
    endfunction

    function automatic word_data_t stored_word(word_addr_t a);
        return mem.exists(a) ? mem[a] : blank_word(a);
    endfunction

    function automatic word_data_t apply_bytes(word_data_t old, word_data_t wdata, byteen_t be);
        word_data_t res;
        res = old;
        for (int i = 0; i < BYTES_W; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // Writes land at acceptance, reads sample the array at acceptance
    always @(posedge clk) begin : accept_side
        mem_rsp_t entry;
        if (reset) begin
            rsp_q.delete();
            due_q.delete();
        end else begin
            cycle++;
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.rw) begin
                    mem[mem_req.addr] = apply_bytes(stored_word(mem_req.addr),
                                                    mem_req.data, mem_req.byteen);
                end else begin
                    entry.data = stored_word(mem_req.addr);
                    entry.tag  = mem_req.tag;
                    rsp_q.push_back(entry);
                    due_q.push_back(cycle + delay_pick);
                end
            end
        end
    end

    // Responses leave in order, head only once its delay ran out
    initial begin
        logic [31:0] rnd;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        forever begin
            @(negedge clk);
            rnd           = $random(seed);
            delay_pick    = int'(rnd[15:8]) % MAX_DELAY;
            mem_req_ready = !reset && (rnd[1:0] != 2'b00);
            if (!reset && rsp_q.size() > 0 && due_q[0] <= cycle) begin
                mem_rsp_valid = 1'b1;
                mem_rsp       = rsp_q[0];
            end else begin
                mem_rsp_valid = 1'b0;
            end
        end
    end

endmodule

//--- testbench/cache_wrap_tb.sv
module cache_wrap_tb
    import cache_pkg::*;
();

    localparam int NUM_LINES   = 16;
    localparam int NC_ADDR_BIT = 15;
    localparam int NUM_REQS    = 400;
    localparam int CACHE_POOL  = 12;
    localparam int NC_POOL     = 4;
    localparam int CLK_PERIOD  = 8;
    localparam int TIMEOUT     = NUM_REQS * 40 * CLK_PERIOD;

    logic      clk = 1'b0;
    logic      reset;
    core_req_t core_req;
    logic      core_req_valid;
    logic      core_req_ready;
    core_rsp_t core_rsp;
    logic      core_rsp_valid;
    logic      core_rsp_ready;
    mem_req_t  mem_req;
    logic      mem_req_valid;
    logic      mem_req_ready;
    mem_rsp_t  mem_rsp;
    logic      mem_rsp_valid;
    logic      mem_rsp_ready;

    integer    seed = 32'h6ed1;
    integer    rsp_seed = 32'h6ed1;

    //////////////////////////////////////////////////////////////////////
    // Reference model state

    word_data_t            model [word_addr_t];
    word_addr_t            cache_pool [CACHE_POOL];
    word_addr_t            nc_pool [NC_POOL];
    logic [NUM_LINES-1:0]  line_ok = '0;
    word_addr_t            line_addr [NUM_LINES];
    logic [(1<<TAG_W)-1:0] busy_tag = '0;
    word_data_t            exp_rsp [1<<TAG_W];
    mem_req_t              exp_cache_q [$];
    mem_req_t              exp_nc_q [$];
    int                    reads_exp [word_addr_t];
    int                    reads_seen [word_addr_t];
    int                    mismatches = 0;
    int                    failures = 0;
    int                    reads_sent = 0;
    int                    rsps_seen = 0;
    int                    mem_reqs_exp = 0;
    int                    mem_reqs_seen = 0;
    logic                  accepted_any = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_wrap #(
        .NUM_LINES   (NUM_LINES),
        .NC_ADDR_BIT (NC_ADDR_BIT)
    ) u_dut (
        .clk            (clk),
        .reset          (reset),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_rsp       (core_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp        (mem_rsp),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    mem_model u_mem (
        .clk           (clk),
        .reset         (reset),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready)
    );

    // Memory contents before any write
    function automatic word_data_t fill_value(word_addr_t a);
        return {a ^ 16'hc35a, ~a};
    endfunction

    function automatic word_data_t model_word(word_addr_t a);
        return model.exists(a) ? model[a] : fill_value(a);
    endfunction

    function automatic word_data_t merge_bytes(word_data_t old, word_data_t wdata, byteen_t be);
        word_data_t res;
        res = old;
        for (int i = 0; i < BYTES_W; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic flag_mismatch(string name, logic [31:0] got, logic [31:0] want);
        mismatches++;
        $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, want);
    endtask

    // Model update at acceptance, with the cache mirrored line by line
    task automatic accept_request(core_req_t r);
        mem_req_t m;
        int       idx;
        m   = '{rw: r.rw, addr: r.addr, byteen: r.byteen, data: r.data, tag: {1'b0, r.tag}};
        idx = int'(r.addr) % NUM_LINES;
        if (r.addr[NC_ADDR_BIT]) begin
            m.tag[MEM_TAG_W-1] = 1'b1;
            exp_nc_q.push_back(m);
            mem_reqs_exp++;
        end else if (r.rw || !(line_ok[idx] && line_addr[idx] == r.addr)) begin
            exp_cache_q.push_back(m);
            mem_reqs_exp++;
            if (!r.rw) begin
                line_ok[idx]      = 1'b1;
                line_addr[idx]    = r.addr;
                reads_exp[r.addr] = reads_exp.exists(r.addr) ? reads_exp[r.addr] + 1 : 1;
            end
        end
        if (r.rw) begin
            model[r.addr] = merge_bytes(model_word(r.addr), r.data, r.byteen);
        end else begin
            busy_tag[r.tag] = 1'b1;
            exp_rsp[r.tag]  = model_word(r.addr);
            reads_sent++;
        end
    endtask

    task automatic check_core_rsp(core_rsp_t r);
        rsps_seen++;
        if (!busy_tag[r.tag]) begin
            failures++;
            $display("Core response at %0t carries tag %0d, which has no read outstanding",
                     $time, r.tag);
        end else begin
            if (r.data !== exp_rsp[r.tag]) begin
                flag_mismatch("core_rsp.data", r.data, exp_rsp[r.tag]);
            end
            busy_tag[r.tag] = 1'b0;
        end
    endtask

    task automatic check_mem_req(mem_req_t r);
        mem_req_t e;
        mem_reqs_seen++;
        if (r.tag[MEM_TAG_W-1] && exp_nc_q.size() > 0) begin
            e = exp_nc_q.pop_front();
        end else if (!r.tag[MEM_TAG_W-1] && exp_cache_q.size() > 0) begin
            e = exp_cache_q.pop_front();
        end else begin
            failures++;
            $display("Memory request at %0t to address %h matches no accepted request",
                     $time, r.addr);
            return;
        end
        if (!r.rw && !r.tag[MEM_TAG_W-1]) begin
            reads_seen[r.addr] = reads_seen.exists(r.addr) ? reads_seen[r.addr] + 1 : 1;
        end
        if (r.rw !== e.rw) begin
            flag_mismatch("mem_req.rw", 32'(r.rw), 32'(e.rw));
        end
        if (r.addr !== e.addr) begin
            flag_mismatch("mem_req.addr", 32'(r.addr), 32'(e.addr));
        end
        if (r.tag !== e.tag) begin
            flag_mismatch("mem_req.tag", 32'(r.tag), 32'(e.tag));
        end
        if (e.rw && r.byteen !== e.byteen) begin
            flag_mismatch("mem_req.byteen", 32'(r.byteen), 32'(e.byteen));
        end
        if (e.rw && r.data !== e.data) begin
            flag_mismatch("mem_req.data", r.data, e.data);
        end
    endtask

    task automatic make_request(output core_req_t r);
        logic [31:0] rnd;
        core_tag_t   t;
        rnd      = $random(seed);
        r.rw     = rnd[0];
        r.byteen = rnd[7:4];
        // About one in four goes around the cache
        if (rnd[9:8] == 2'b00) begin
            r.addr = nc_pool[rnd[17:16]];
        end else begin
            r.addr = cache_pool[int'(rnd[27:20]) % CACHE_POOL];
        end
        r.data = $random(seed);
        do begin
            rnd = $random(seed);
            t   = rnd[TAG_W-1:0];
        end while (busy_tag[t]);
        r.tag = t;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitor

    always @(posedge clk) begin
        if (!reset) begin
            if (!accepted_any && (core_rsp_valid || mem_req_valid)) begin
                failures++;
                $display("Output valid raised at %0t before any request was accepted", $time);
            end
            if (core_req_valid && core_req_ready) begin
                accept_request(core_req);
                accepted_any = 1'b1;
            end
            if (core_rsp_valid && core_rsp_ready) begin
                check_core_rsp(core_rsp);
            end
            if (mem_req_valid && mem_req_ready) begin
                check_mem_req(mem_req);
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        core_rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            rnd            = $random(rsp_seed);
            core_rsp_ready = (rnd[5:4] != 2'b00);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus and final report

    initial begin
        core_req_t   r;
        logic [31:0] rnd;
        int          gap;
        reset          = 1'b1;
        core_req       = '0;
        core_req_valid = 1'b0;
        // Small pools so that lines get hit and evicted
        for (int i = 0; i < CACHE_POOL; i++) begin
            rnd           = $random(seed);
            cache_pool[i] = {10'h000, rnd[5:0]};
        end
        for (int i = 0; i < NC_POOL; i++) begin
            rnd        = $random(seed);
            nc_pool[i] = {1'b1, 9'h000, rnd[5:0]};
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;
        repeat (5) @(negedge clk);
        for (int n = 0; n < NUM_REQS; n++) begin
            make_request(r);
            core_req       = r;
            core_req_valid = 1'b1;
            @(posedge clk);
            while (!core_req_ready) begin
                @(posedge clk);
            end
            @(negedge clk);
            core_req_valid = 1'b0;
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk);
        end
        while (busy_tag != '0 || exp_cache_q.size() != 0 || exp_nc_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);

        foreach (reads_exp[a]) begin
            if (!reads_seen.exists(a) || reads_seen[a] != reads_exp[a]) begin
                failures++;
                $display("Cached address %h saw the wrong number of memory reads", a);
            end
        end
        foreach (reads_seen[a]) begin
            if (!reads_exp.exists(a)) begin
                failures++;
                $display("Cached address %h was read from memory on a hit", a);
            end
        end
        if (rsps_seen != reads_sent || mem_reqs_seen != mem_reqs_exp) begin
            failures++;
            $display("Counts do not balance: %0d reads, %0d responses, %0d of %0d memory requests",
                     reads_sent, rsps_seen, mem_reqs_seen, mem_reqs_exp);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Run stopped by the watchdog after %0d time units, %0d reads still open",
                 TIMEOUT, $countones(busy_tag));
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- cache_wrap.f
logic/cache_pkg.sv
logic/skid_buffer.sv
logic/nc_bypass.sv
logic/cache_core.sv
logic/cache_wrap.sv
testbench/mem_model.sv
testbench/cache_wrap_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the cache wrapper testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f cache_wrap.f --top-module cache_wrap_tb \
    -Mdir "$BUILD_DIR" -o sim_cache_wrap > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_cache_wrap" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAIL" "$SIM_LOG"; then
    exit 1
fi
exit 0
